/* rtl/rv_isa_pkg.sv */
/*
 * RV32 integer ISA encoding definitions
 *  - instruction word, register index and register value types
 *  - opcode, funct3 and funct7 field types
 *  - major opcodes of the ALU instructions
 *  - funct3 and funct7 codes
 *  - bit positions of the instruction fields
 */
package rv_isa_pkg;

  // Plain-vector types of the ISA
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  rf_addr_t;
  typedef logic [31:0] rf_data_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////
  localparam opcode_t OPCODE_OP     = 7'b0110011;
  localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
  localparam opcode_t OPCODE_LUI    = 7'b0110111;

  // funct3 codes, shared by OP and OP-IMM
  localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
  localparam funct3_t FUNCT3_SLL     = 3'b001;
  localparam funct3_t FUNCT3_SLT     = 3'b010;
  localparam funct3_t FUNCT3_SLTU    = 3'b011;
  localparam funct3_t FUNCT3_XOR     = 3'b100;
  localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
  localparam funct3_t FUNCT3_OR      = 3'b110;
  localparam funct3_t FUNCT3_AND     = 3'b111;

  // funct7 codes
  // ALT selects SUB and SRA
  localparam funct7_t FUNCT7_BASE = 7'b0000000;
  localparam funct7_t FUNCT7_ALT  = 7'b0100000;

  //////////////////////////////
  // Field positions (lsb)
  //////////////////////////////
  localparam int RD_POS     = 7;
  localparam int FUNCT3_POS = 12;
  localparam int RS1_POS    = 15;
  localparam int RS2_POS    = 20;
  localparam int FUNCT7_POS = 25;

endpackage

/* rtl/pipe_pkg.sv */
/*
 * Pipeline definitions
 *  - ALU operation enum
 *  - ID/EX and EX/WB stage structs
 *  - retired result payload of the output stream
 */
package pipe_pkg;

  // ALU operations
  // LUI travels as ADD of the U immediate to zero
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Decode to execute
  typedef struct packed {
    logic                 valid;
    alu_op_e              alu_op;
    rv_isa_pkg::rf_data_t operand_a;
    rv_isa_pkg::rf_data_t operand_b;
    rv_isa_pkg::rf_addr_t rd;
    logic                 rf_we;
    logic                 illegal;
  } id_ex_pipe_t;

  // Execute to result stage, also the bypass format
  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::rf_addr_t rd;
    logic                 rf_we;
    logic                 illegal;
    rv_isa_pkg::rf_data_t result;
  } ex_wb_pipe_t;

  // Output stream payload
  typedef struct packed {
    rv_isa_pkg::rf_addr_t rd;
    rv_isa_pkg::rf_data_t data;
    logic                 illegal;
  } result_t;

endpackage

/* rtl/register_file.sv */
/*
 * Flip-flop register file
 *  - two combinational read ports
 *  - one write port
 *  - x0 hard-wired to zero
 */
`timescale 1ns/1ps

module register_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  rv_isa_pkg::rf_addr_t raddr_a_i,
  input  rv_isa_pkg::rf_addr_t raddr_b_i,
  input  logic                 we_i,
  input  rv_isa_pkg::rf_addr_t waddr_i,
  input  rv_isa_pkg::rf_data_t wdata_i,
  output rv_isa_pkg::rf_data_t rdata_a_o,
  output rv_isa_pkg::rf_data_t rdata_b_o
);
  import rv_isa_pkg::*;

  // x0 has no storage
  rf_data_t regs_q [1:NUM_REGS-1];

  // Implemented register other than x0
  function automatic logic in_range(input rf_addr_t addr);
    return (addr != '0) && (int'(addr) < NUM_REGS);
  endfunction

  // Reads of x0 or of a missing register give zero
  assign rdata_a_o = in_range(raddr_a_i) ? regs_q[raddr_a_i] : '0;
  assign rdata_b_o = in_range(raddr_b_i) ? regs_q[raddr_b_i] : '0;

  // Write port
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && in_range(waddr_i)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

/* rtl/id_stage.sv */
/*
 * Decode stage
 *  - opcode, funct3 and funct7 decode into the ALU operation
 *  - I and U immediates, illegal encoding and register range checks
 *  - operand bypass from the later stages
 *  - ID/EX pipeline register
 */
`timescale 1ns/1ps

module id_stage #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  instr_valid_i,
  input  rv_isa_pkg::instr_t    instr_i,
  input  logic                  ex_ready_i,
  input  pipe_pkg::ex_wb_pipe_t ex_fwd_i,
  input  pipe_pkg::ex_wb_pipe_t wb_fwd_i,
  input  rv_isa_pkg::rf_data_t  rf_rdata_a_i,
  input  rv_isa_pkg::rf_data_t  rf_rdata_b_i,
  output logic                  instr_ready_o,
  output pipe_pkg::id_ex_pipe_t id_ex_pipe_o,
  output rv_isa_pkg::rf_addr_t  rf_raddr_a_o,
  output rv_isa_pkg::rf_addr_t  rf_raddr_b_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  opcode_t     opcode;
  funct3_t     funct3;
  funct7_t     funct7;
  rf_addr_t    rd;
  rf_addr_t    rs1;
  rf_addr_t    rs2;
  rf_data_t    imm_i;
  rf_data_t    imm_u;
  rf_data_t    rs1_val;
  rf_data_t    rs2_val;
  alu_op_e     alu_op;
  logic        use_rs1;
  logic        use_rs2;
  logic        is_lui;
  logic        dec_illegal;
  logic        illegal;
  id_ex_pipe_t id_ex_d;
  id_ex_pipe_t id_ex_q;
  // Copy of the item last handed to execute, i.e. the EX/WB entry
  ex_wb_pipe_t last_ex_q;

  // funct3 to operation, base (non-ALT) encodings
  function automatic alu_op_e base_op(input funct3_t f3);
    alu_op_e op;
    case (f3)
      FUNCT3_ADD_SUB: op = ALU_ADD;
      FUNCT3_SLL:     op = ALU_SLL;
      FUNCT3_SLT:     op = ALU_SLT;
      FUNCT3_SLTU:    op = ALU_SLTU;
      FUNCT3_XOR:     op = ALU_XOR;
      FUNCT3_SRL_SRA: op = ALU_SRL;
      FUNCT3_OR:      op = ALU_OR;
      FUNCT3_AND:     op = ALU_AND;
      default:        op = ALU_ADD;
    endcase
    return op;
  endfunction

  function automatic logic reg_oob(input rf_addr_t idx);
    return int'(idx) >= NUM_REGS;
  endfunction

  function automatic logic fwd_hit(input ex_wb_pipe_t src, input rf_addr_t idx);
    return src.valid && src.rf_we && (src.rd == idx);
  endfunction

  // Newest producer wins, register file last
  function automatic rf_data_t fwd_sel(input rf_addr_t idx, input rf_data_t rf_val,
                                       input ex_wb_pipe_t ex_src, input ex_wb_pipe_t last_src,
                                       input ex_wb_pipe_t wb_src);
    rf_data_t val;
    if (idx == '0) begin
      val = '0;
    end else if (fwd_hit(ex_src, idx)) begin
      val = ex_src.result;
    end else if (fwd_hit(last_src, idx)) begin
      val = last_src.result;
    end else if (fwd_hit(wb_src, idx)) begin
      val = wb_src.result;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  //////////////////////////////
  // Decoder
  //////////////////////////////
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[FUNCT3_POS +: 3];
  assign funct7 = instr_i[FUNCT7_POS +: 7];
  assign rd     = instr_i[RD_POS +: 5];
  assign rs1    = instr_i[RS1_POS +: 5];
  assign rs2    = instr_i[RS2_POS +: 5];
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u  = {instr_i[31:12], 12'b0};

  always_comb begin
    alu_op      = ALU_ADD;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    is_lui      = 1'b0;
    dec_illegal = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        if (funct7 == FUNCT7_BASE) begin
          alu_op = base_op(funct3);
        end else if (funct7 == FUNCT7_ALT && funct3 == FUNCT3_ADD_SUB) begin
          alu_op = ALU_SUB;
        end else if (funct7 == FUNCT7_ALT && funct3 == FUNCT3_SRL_SRA) begin
          alu_op = ALU_SRA;
        end else begin
          dec_illegal = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        use_rs1 = 1'b1;
        alu_op  = base_op(funct3);
        // Shift immediates use funct7 as an opcode extension
        if (funct3 == FUNCT3_SLL && funct7 != FUNCT7_BASE) begin
          dec_illegal = 1'b1;
        end else if (funct3 == FUNCT3_SRL_SRA && funct7 == FUNCT7_ALT) begin
          alu_op = ALU_SRA;
        end else if (funct3 == FUNCT3_SRL_SRA && funct7 != FUNCT7_BASE) begin
          dec_illegal = 1'b1;
        end
      end
      OPCODE_LUI: begin
        is_lui = 1'b1;
      end
      default: begin
        dec_illegal = 1'b1;
      end
    endcase
  end

  // Index beyond the implemented registers
  assign illegal = dec_illegal || reg_oob(rd) || (use_rs1 && reg_oob(rs1)) ||
                   (use_rs2 && reg_oob(rs2));

  //////////////////////////////
  // Operands and bypass
  //////////////////////////////
  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;
  assign rs1_val = fwd_sel(rs1, rf_rdata_a_i, ex_fwd_i, last_ex_q, wb_fwd_i);
  assign rs2_val = fwd_sel(rs2, rf_rdata_b_i, ex_fwd_i, last_ex_q, wb_fwd_i);

  // Illegal items carry zero operands and so retire with zero data
  always_comb begin
    id_ex_d.valid     = instr_valid_i;
    id_ex_d.alu_op    = illegal ? ALU_ADD : alu_op;
    id_ex_d.operand_a = (illegal || is_lui) ? '0 : rs1_val;
    id_ex_d.operand_b = illegal ? '0 : use_rs2 ? rs2_val : is_lui ? imm_u : imm_i;
    id_ex_d.rd        = rd;
    id_ex_d.rf_we     = !illegal;
    id_ex_d.illegal   = illegal;
  end

  //////////////////////////////
  // ID/EX register
  //////////////////////////////
  assign instr_ready_o = ex_ready_i || !id_ex_q.valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_q   <= '0;
      last_ex_q <= '0;
    end else begin
      if (instr_ready_o) begin
        id_ex_q <= id_ex_d;
      end
      // Track what execute registers on this edge
      if (id_ex_q.valid && ex_ready_i) begin
        last_ex_q <= ex_fwd_i;
      end
    end
  end

  assign id_ex_pipe_o = id_ex_q;

endmodule

/* rtl/ex_stage.sv */
/*
 * Execute stage
 *  - ALU for add, sub, shifts, compares and logic ops
 *  - combinational bypass of the ALU result
 *  - EX/WB pipeline register
 */
`timescale 1ns/1ps

module ex_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  pipe_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  logic                  wb_ready_i,
  output logic                  ex_ready_o,
  output pipe_pkg::ex_wb_pipe_t ex_wb_pipe_o,
  output pipe_pkg::ex_wb_pipe_t ex_fwd_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  rf_data_t    op_a;
  rf_data_t    op_b;
  logic [4:0]  shamt;
  rf_data_t    alu_result;
  ex_wb_pipe_t ex_item;
  ex_wb_pipe_t ex_wb_q;

  assign op_a  = id_ex_pipe_i.operand_a;
  assign op_b  = id_ex_pipe_i.operand_b;
  // Shift amount from the low bits only
  assign shamt = op_b[4:0];

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (id_ex_pipe_i.alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = '0;
    endcase
  end

  assign ex_item = '{
    valid:   id_ex_pipe_i.valid,
    rd:      id_ex_pipe_i.rd,
    rf_we:   id_ex_pipe_i.rf_we,
    illegal: id_ex_pipe_i.illegal,
    result:  alu_result
  };

  // Bypass only for a live item that writes
  always_comb begin
    ex_fwd_o       = ex_item;
    ex_fwd_o.valid = id_ex_pipe_i.valid && id_ex_pipe_i.rf_we;
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////
  assign ex_ready_o = wb_ready_i || !ex_wb_q.valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_wb_q <= '0;
    end else if (ex_ready_o) begin
      ex_wb_q <= ex_item;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

/* rtl/wb_stage.sv */
/*
 * Result stage
 *  - holding register for the retiring item
 *  - output valid/ready stream
 *  - register write on the leaving handshake
 */
`timescale 1ns/1ps

module wb_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  pipe_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  logic                  result_ready_i,
  output logic                  wb_ready_o,
  output logic                  result_valid_o,
  output pipe_pkg::result_t     result_o,
  output pipe_pkg::ex_wb_pipe_t wb_fwd_o,
  output logic                  rf_we_o,
  output rv_isa_pkg::rf_addr_t  rf_waddr_o,
  output rv_isa_pkg::rf_data_t  rf_wdata_o
);
  import pipe_pkg::*;

  ex_wb_pipe_t wb_q;
  logic        leave;

  // Item leaves on the output handshake
  assign leave      = wb_q.valid && result_ready_i;
  assign wb_ready_o = result_ready_i || !wb_q.valid;

  // Holds steady while the sink stalls
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_q <= '0;
    end else if (wb_ready_o) begin
      wb_q <= ex_wb_pipe_i;
    end
  end

  assign result_valid_o = wb_q.valid;
  assign result_o       = '{rd: wb_q.rd, data: wb_q.result, illegal: wb_q.illegal};

  // Not yet in the register file, so offer it to decode
  assign wb_fwd_o = wb_q;

  // Commit; illegal items and x0 never write
  assign rf_we_o    = leave && wb_q.rf_we && !wb_q.illegal && (wb_q.rd != '0);
  assign rf_waddr_o = wb_q.rd;
  assign rf_wdata_o = wb_q.result;

endmodule

/* rtl/int_pipe_core.sv */
/*
 * Three-stage RV32 integer pipeline top level
 *  - decode, execute and result stages
 *  - register file
 */
`timescale 1ns/1ps

module int_pipe_core #(
  parameter int NUM_REGS = 32
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               instr_valid_i,
  input  rv_isa_pkg::instr_t instr_i,
  input  logic               result_ready_i,
  output logic               instr_ready_o,
  output logic               result_valid_o,
  output pipe_pkg::result_t  result_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  // Stage to stage
  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;
  logic        ex_ready;
  logic        wb_ready;

  // Bypass paths
  ex_wb_pipe_t ex_fwd;
  ex_wb_pipe_t wb_fwd;

  // Register file ports
  rf_addr_t    rf_raddr_a;
  rf_addr_t    rf_raddr_b;
  rf_data_t    rf_rdata_a;
  rf_data_t    rf_rdata_b;
  logic        rf_we;
  rf_addr_t    rf_waddr;
  rf_data_t    rf_wdata;

  //////////////////////////////
  // Decode
  //////////////////////////////
  id_stage #(
    .NUM_REGS      ( NUM_REGS       )
  ) id_stage_i (
    .clk_i         ( clk_i          ),
    .arst_n_i      ( arst_n_i       ),
    .instr_valid_i ( instr_valid_i  ),
    .instr_i       ( instr_i        ),
    .ex_ready_i    ( ex_ready       ),
    .ex_fwd_i      ( ex_fwd         ),
    .wb_fwd_i      ( wb_fwd         ),
    .rf_rdata_a_i  ( rf_rdata_a     ),
    .rf_rdata_b_i  ( rf_rdata_b     ),
    .instr_ready_o ( instr_ready_o  ),
    .id_ex_pipe_o  ( id_ex_pipe     ),
    .rf_raddr_a_o  ( rf_raddr_a     ),
    .rf_raddr_b_o  ( rf_raddr_b     )
  );

  // Execute
  ex_stage ex_stage_i (
    .clk_i         ( clk_i          ),
    .arst_n_i      ( arst_n_i       ),
    .id_ex_pipe_i  ( id_ex_pipe     ),
    .wb_ready_i    ( wb_ready       ),
    .ex_ready_o    ( ex_ready       ),
    .ex_wb_pipe_o  ( ex_wb_pipe     ),
    .ex_fwd_o      ( ex_fwd         )
  );

  // Result stage and output stream
  wb_stage wb_stage_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .ex_wb_pipe_i   ( ex_wb_pipe     ),
    .result_ready_i ( result_ready_i ),
    .wb_ready_o     ( wb_ready       ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o       ),
    .wb_fwd_o       ( wb_fwd         ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       )
  );

  //////////////////////////////
  // Register file
  //////////////////////////////
  register_file #(
    .NUM_REGS  ( NUM_REGS   )
  ) register_file_i (
    .clk_i     ( clk_i      ),
    .arst_n_i  ( arst_n_i   ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .we_i      ( rf_we      ),
    .waddr_i   ( rf_waddr   ),
    .wdata_i   ( rf_wdata   ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b )
  );

endmodule

/* dv/int_pipe_core_assertions.sv */
/*
 * Output stream protocol assertions
 *  - stalled result holds steady
 *  - no result during reset
 *  - no unknown payload on a valid result
 */
`timescale 1ns/1ps

module int_pipe_core_assertions (
  input logic              clk_i,
  input logic              arst_n_i,
  input logic              result_valid_o,
  input logic              result_ready_i,
  input pipe_pkg::result_t result_o
);

  // Stalled result stays until taken
  result_stable_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o))
  ) else $error("Output result changed while the sink stalled");

  // Empty pipeline in reset
  reset_quiet_a: assert property (
    @(posedge clk_i) !arst_n_i |-> !result_valid_o
  ) else $error("Output valid high during reset");

  ////////////////////////////
  result_known_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o |-> !$isunknown(result_o)
  ) else $error("Unknown bits on a valid output result");

endmodule

/* dv/int_pipe_core_tb.sv */
/*
 * Testbench for the three-stage integer pipeline
 *  - clock, reset and instruction stream stimulus
 *  - reference model with its own register file
 *  - result comparison, timeout and assertion binding
 */
`timescale 1ns/1ps

module int_pipe_core_tb;
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam int NUM_REGS   = 32;
  localparam int SEED       = 29;
  // About 600 instructions, stalls and a margin of ten
  localparam int MAX_CYCLES = 20000;
  localparam int N_PLAIN    = 250;
  localparam int N_STALL    = 300;

  logic    clk_i;
  logic    arst_n_i;
  logic    instr_valid_i;
  instr_t  instr_i;
  logic    result_ready_i;
  logic    instr_ready_o;
  logic    result_valid_o;
  result_t result_o;

  // Model state
  rf_data_t model_regs [NUM_REGS];
  result_t  exp_q [$];
  rf_addr_t recent_rd [$];
  logic     stall_en  = 1'b0;
  logic     fail_seen = 1'b0;
  logic     run_done  = 1'b0;
  int       cycles;

  int_pipe_core #(
    .NUM_REGS       ( NUM_REGS       )
  ) DUT (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .result_ready_i ( result_ready_i ),
    .instr_ready_o  ( instr_ready_o  ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o       )
  );

  bind int_pipe_core int_pipe_core_assertions assertions_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .result_valid_o ( result_valid_o ),
    .result_ready_i ( result_ready_i ),
    .result_o       ( result_o       )
  );

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    fail_seen = 1'b1;
    $display("Checks failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                         $time, name, got, want));
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic out_of_range(input rf_addr_t idx);
    return int'(idx) >= NUM_REGS;
  endfunction

  // Expected retirement of one instruction, updates the model registers
  function automatic result_t model_result(input instr_t ins);
    result_t  res;
    rf_addr_t rd;
    rf_addr_t rs1;
    rf_addr_t rs2;
    rf_data_t a;
    rf_data_t b;
    rf_data_t imm;
    rf_data_t val;
    logic     bad;
    rd  = ins[11:7];
    rs1 = ins[19:15];
    rs2 = ins[24:20];
    a   = model_regs[rs1];
    b   = model_regs[rs2];
    imm = {{20{ins[31]}}, ins[31:20]};
    val = '0;
    bad = 1'b0;
    case (ins[6:0])
      // OP, keyed on funct7 and funct3
      7'b0110011: begin
        bad = out_of_range(rs1) || out_of_range(rs2);
        case ({ins[31:25], ins[14:12]})
          10'b0000000_000: val = a + b;
          10'b0100000_000: val = a - b;
          10'b0000000_001: val = a << b[4:0];
          10'b0000000_010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          10'b0000000_011: val = (a < b) ? 32'd1 : 32'd0;
          10'b0000000_100: val = a ^ b;
          10'b0000000_101: val = a >> b[4:0];
          10'b0100000_101: val = rf_data_t'($signed(a) >>> b[4:0]);
          10'b0000000_110: val = a | b;
          10'b0000000_111: val = a & b;
          default:         bad = 1'b1;
        endcase
      end
      // OP-IMM
      7'b0010011: begin
        bad = out_of_range(rs1);
        case (ins[14:12])
          3'b000: val = a + imm;
          3'b010: val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          3'b011: val = (a < imm) ? 32'd1 : 32'd0;
          3'b100: val = a ^ imm;
          3'b110: val = a | imm;
          3'b111: val = a & imm;
          3'b001: begin
            if (ins[31:25] == 7'b0000000) begin
              val = a << ins[24:20];
            end else begin
              bad = 1'b1;
            end
          end
          default: begin
            if (ins[31:25] == 7'b0000000) begin
              val = a >> ins[24:20];
            end else if (ins[31:25] == 7'b0100000) begin
              val = rf_data_t'($signed(a) >>> ins[24:20]);
            end else begin
              bad = 1'b1;
            end
          end
        endcase
      end
      // LUI
      7'b0110111: val = {ins[31:12], 12'b0};
      default:    bad = 1'b1;
    endcase
    bad = bad || out_of_range(rd);
    // Illegal retires with zero data; x0 stays zero
    if (bad) begin
      val = '0;
    end else if (rd != '0) begin
      model_regs[rd] = val;
    end
    res.rd      = rd;
    res.data    = val;
    res.illegal = bad;
    return res;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  // Half the picks reuse a recent rd to exercise the bypass
  function automatic rf_addr_t pick_reg();
    int idx;
    if (recent_rd.size() != 0 && ($urandom % 2) == 0) begin
      idx = int'($urandom % 32'(recent_rd.size()));
      return recent_rd[idx];
    end
    return rf_addr_t'($urandom % 32);
  endfunction

  function automatic instr_t illegal_word();
    case ($urandom % 4)
      0: return {12'($urandom), 5'($urandom), 3'b010, 5'($urandom), 7'b0000011};
      1: return {7'b0000001, 5'($urandom), 5'($urandom), 3'($urandom), 5'($urandom),
                 7'b0110011};
      2: return {7'b0100000, 5'($urandom), 5'($urandom), 3'b111, 5'($urandom), 7'b0110011};
      default: return {7'b0100000, 5'($urandom), 5'($urandom), 3'b001, 5'($urandom),
                       7'b0010011};
    endcase
  endfunction

  function automatic instr_t rand_instr();
    rf_addr_t   rd;
    rf_addr_t   rs1;
    rf_addr_t   rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    int         kind;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = 3'($urandom);
    imm  = 12'($urandom);
    kind = int'($urandom % 16);
    if (kind < 7) begin
      f7 = 7'b0000000;
      if ((f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2) == 1) begin
        f7 = 7'b0100000;
      end
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
    end else if (kind < 13) begin
      // Legal shift immediates only
      if (f3 == 3'b001) begin
        imm[11:5] = 7'b0000000;
      end else if (f3 == 3'b101) begin
        imm[11:5] = (($urandom % 2) == 1) ? 7'b0100000 : 7'b0000000;
      end
      return {imm, rs1, f3, rd, 7'b0010011};
    end else if (kind < 15) begin
      return {20'($urandom), rd, 7'b0110111};
    end
    return illegal_word();
  endfunction

  // Hold the word until the handshake, then log the expectation
  task automatic issue(input instr_t ins);
    instr_valid_i <= 1'b1;
    instr_i       <= ins;
    @(posedge clk_i);
    while (!instr_ready_o) begin
      @(posedge clk_i);
    end
    exp_q.push_back(model_result(ins));
    recent_rd.push_back(ins[11:7]);
    if (recent_rd.size() > 3) begin
      void'(recent_rd.pop_front());
    end
  endtask

  task automatic idle_cycle();
    instr_valid_i <= 1'b0;
    @(posedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Sink, stalls about half the time when enabled
  initial begin : drive_ready
    result_ready_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      result_ready_i <= stall_en ? 1'($urandom % 2) : 1'b1;
    end
  end

  initial begin : run_tests
    void'($urandom(SEED));
    arst_n_i      <= 1'b0;
    instr_valid_i <= 1'b0;
    instr_i       <= '0;
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Nothing retires before the first instruction
    repeat (4) begin
      @(posedge clk_i);
      check_value("result_valid_o", 32'(result_valid_o), 32'd0);
      check_value("instr_ready_o", 32'(instr_ready_o), 32'd1);
    end

    // Every register reads zero after reset
    for (int r = 0; r < NUM_REGS; r++) begin
      issue({7'b0, rf_addr_t'(r), rf_addr_t'(NUM_REGS - 1 - r), 3'b110, rf_addr_t'(r),
             7'b0110011});
    end

    // x0 writes and an illegal load leave registers alone
    issue({20'hABCDE, 5'd5, 7'b0110111});
    issue({12'h123, 5'd5, 3'b000, 5'd0, 7'b0010011});
    issue({7'b0, 5'd0, 5'd5, 3'b000, 5'd6, 7'b0110011});
    issue({12'h004, 5'd5, 3'b010, 5'd5, 7'b0000011});
    issue({7'b0, 5'd5, 5'd0, 3'b110, 5'd7, 7'b0110011});

    // Random mix, sink always ready
    repeat (N_PLAIN) issue(rand_instr());

    // Random mix under back-pressure and input gaps
    stall_en = 1'b1;
    repeat (N_STALL) begin
      if (($urandom % 8) == 0) begin
        idle_cycle();
      end
      issue(rand_instr());
    end
    instr_valid_i <= 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    run_done = 1'b1;
    $display("All checks passed");
    $finish;
  end

  //////////////////////////////
  // Comparison
  //////////////////////////////
  initial begin : compare_results
    result_t want;
    forever begin
      @(posedge clk_i);
      if (arst_n_i && result_valid_o && result_ready_i) begin
        if (exp_q.size() == 0) begin
          fail_run($sformatf("A result left at %0t with no instruction outstanding", $time));
        end else begin
          want = exp_q.pop_front();
          check_value("result_o.rd", 32'(result_o.rd), 32'(want.rd));
          check_value("result_o.data", result_o.data, want.data);
          check_value("result_o.illegal", 32'(result_o.illegal), 32'(want.illegal));
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    fail_run($sformatf("Timeout after %0d cycles with %0d results still pending",
                       cycles, exp_q.size()));
  end

  // Run stopped by an assertion or otherwise cut short
  final begin
    if (!run_done && !fail_seen) begin
      $display("Checks failed");
    end
  end

endmodule

/* int_pipe_core.f */
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/register_file.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/wb_stage.sv
rtl/int_pipe_core.sv
dv/int_pipe_core_assertions.sv
dv/int_pipe_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the int_pipe_core testbench with Verilator
set -u

ROOT="$(cd "$(dirname "$0")" && pwd)"
cd "$ROOT" || exit 1

TOP=int_pipe_core_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert -f int_pipe_core.f \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "^All checks passed$" "$LOG"; then
  echo "PASS (simulator exit status $sim_status)"
  exit 0
fi
echo "FAIL: pass message not found in $LOG (simulator exit status $sim_status)"
exit 1
